//--- Makefile
TOP = adc_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- list.f
source/adc_pkg.sv
source/intan_if.sv
source/intan_ctrl.sv
source/intan_chan.sv
source/fifo2adc.sv
source/adc.sv
test/adc_props.sv
test/adc_tb.sv

//--- source/adc.sv
`timescale 1ns/1ps

module adc #(
    parameter int SCLK_DIV   = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                       sys_clk,
    input  logic                                       reset,

    input  logic                                       fs_check,
    input  logic                                       fs_conf,
    input  logic                                       fs_read,
    input  logic                                       fs_fifo,
    output logic                                       fd_check,
    output logic                                       fd_conf,
    output logic                                       fd_read,
    output logic                                       fd_fifo,

    input  logic [adc_pkg::N_SLOT*adc_pkg::KIND_W-1:0] dev_kind,
    output logic [adc_pkg::N_SLOT*adc_pkg::KIND_W-1:0] dev_type,
    input  logic [adc_pkg::N_SLOT*adc_pkg::WORD_W-1:0] adc_cmd,

    output logic                                       adc_rxen,
    output logic [adc_pkg::BYTE_W-1:0]                 adc_rxd,
    output logic                                       fifoa_full,
    output logic                                       fifoa_empty,

    output logic [adc_pkg::N_SLOT-1:0]                 sclk,
    output logic [adc_pkg::N_SLOT-1:0]                 cs_n,
    output logic [adc_pkg::N_SLOT-1:0]                 mosi,
    input  logic [adc_pkg::N_SLOT-1:0]                 miso
);
    import adc_pkg::*;

    intan_if slot_bus [N_SLOT] ();

    intan_ctrl u_ctrl (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .fs_check (fs_check),
        .fs_conf  (fs_conf),
        .fs_read  (fs_read),
        .dev_kind (dev_kind),
        .fd_check (fd_check),
        .fd_conf  (fd_conf),
        .fd_read  (fd_read),
        .slot     (slot_bus)
    );

    // slot i takes bits i of the SPI buses, slot 3 sits in the top bits
    for (genvar i = 0; i < N_SLOT; i++) begin : g_chan
        intan_chan #(
            .SCLK_DIV   (SCLK_DIV),
            .FIFO_DEPTH (FIFO_DEPTH),
            .SLOT       (i)
        ) u_chan (
            .sys_clk (sys_clk),
            .reset   (reset),
            .kind    (dev_kind[KIND_W*i +: KIND_W]),
            .cmd     (adc_cmd[WORD_W*i +: WORD_W]),
            .miso    (miso[i]),
            .sclk    (sclk[i]),
            .cs_n    (cs_n[i]),
            .mosi    (mosi[i]),
            .bus     (slot_bus[i])
        );
    end

    fifo2adc u_drain (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .fs_fifo     (fs_fifo),
        .fd_fifo     (fd_fifo),
        .adc_rxen    (adc_rxen),
        .adc_rxd     (adc_rxd),
        .fifoa_full  (fifoa_full),
        .fifoa_empty (fifoa_empty),
        .dev_type    (dev_type),
        .slot        (slot_bus)
    );

endmodule

//--- source/adc_pkg.sv
package adc_pkg;

    // slot count and frame widths
    localparam int N_SLOT = 4;
    localparam int WORD_W = 16;
    localparam int KIND_W = 2;
    localparam int BYTE_W = 8;

    // identity byte each chip returns in the low byte of a check frame
    localparam logic [BYTE_W-1:0] CHIP_ID [N_SLOT] = '{
        8'hF0,
        8'hF4,
        8'hF8,
        8'hFC
    };

    // identity request, top two bits set
    localparam logic [WORD_W-1:0] CMD_CHECK = {2'b11, {(WORD_W-2){1'b0}}};

    // convert request, top bit clear
    localparam logic [WORD_W-1:0] CMD_CONVERT = '0;

    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_CHECK = 2'd1,
        OP_CONF  = 2'd2,
        OP_READ  = 2'd3
    } op_t;

endpackage

//--- source/fifo2adc.sv
`timescale 1ns/1ps

module fifo2adc (
    input  logic                                       sys_clk,
    input  logic                                       reset,
    input  logic                                       fs_fifo,
    output logic                                       fd_fifo,
    output logic                                       adc_rxen,
    output logic [adc_pkg::BYTE_W-1:0]                 adc_rxd,
    output logic                                       fifoa_full,
    output logic                                       fifoa_empty,
    output logic [adc_pkg::N_SLOT*adc_pkg::KIND_W-1:0] dev_type,
    intan_if.drain                                     slot [adc_pkg::N_SLOT]
);
    import adc_pkg::*;

    localparam int SLOT_W = (N_SLOT > 1) ? $clog2(N_SLOT) : 1;

    // header, high byte, low byte, then one idle cycle
    typedef enum logic [1:0] {ST_PICK, ST_HIGH, ST_LOW, ST_GAP} state_t;

    state_t            state;
    logic              en;
    logic [SLOT_W-1:0] last;
    logic [SLOT_W-1:0] next;
    logic              found;
    logic              take;
    logic              all_empty;
    logic [N_SLOT-1:0] empty_vec;
    logic [N_SLOT-1:0] full_vec;
    logic [N_SLOT-1:0] pop_vec;
    logic [KIND_W-1:0] kind_chk [N_SLOT];
    logic [WORD_W-1:0] head [N_SLOT];
    logic [WORD_W-1:0] word_q;

    for (genvar i = 0; i < N_SLOT; i++) begin : g_slot
        assign empty_vec[i] = slot[i].empty;
        assign full_vec[i]  = slot[i].full;
        // failed identity check reads as an empty slot
        assign kind_chk[i]  = slot[i].kind_ok ? slot[i].kind : '0;
        assign head[i]      = slot[i].rd_data;
        assign slot[i].rd_en = pop_vec[i];
        assign dev_type[KIND_W*i +: KIND_W] = kind_chk[i];
    end

    assign all_empty   = &empty_vec;
    assign fifoa_empty = all_empty;
    assign fifoa_full  = |full_vec;

    // first non-empty slot after the one served last
    always_comb begin
        int j;
        j     = 0;
        found = 1'b0;
        next  = last;
        for (int k = 1; k <= N_SLOT; k++) begin
            j = (int'(last) + k) % N_SLOT;
            if (!found && !empty_vec[j]) begin
                found = 1'b1;
                next  = SLOT_W'(j);
            end
        end
    end

    assign take    = (state == ST_PICK) && en && found;
    assign pop_vec = take ? (N_SLOT'(1) << next) : '0;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state    <= ST_PICK;
            en       <= 1'b0;
            last     <= SLOT_W'(N_SLOT - 1);
            adc_rxen <= 1'b0;
            fd_fifo  <= 1'b0;
        end else begin
            adc_rxen <= 1'b0;
            fd_fifo  <= 1'b0;
            case (state)
                ST_PICK: begin
                    if (take) begin
                        last     <= next;
                        adc_rxen <= 1'b1;
                        state    <= ST_HIGH;
                    end else if (en && all_empty) begin
                        fd_fifo <= 1'b1;
                        en      <= 1'b0;
                    end
                end
                ST_HIGH: begin
                    adc_rxen <= 1'b1;
                    state    <= ST_LOW;
                end
                ST_LOW: begin
                    adc_rxen <= 1'b1;
                    state    <= ST_GAP;
                end
                default: begin
                    state <= ST_PICK;
                    if (all_empty) begin
                        fd_fifo <= 1'b1;
                        en      <= 1'b0;
                    end
                end
            endcase
            if (fs_fifo) begin
                en <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        case (state)
            ST_PICK: begin
                if (take) begin
                    word_q  <= head[next];
                    adc_rxd <= BYTE_W'({kind_chk[next], next});
                end
            end
            ST_HIGH: adc_rxd <= word_q[WORD_W-1 -: BYTE_W];
            ST_LOW:  adc_rxd <= word_q[BYTE_W-1:0];
            default: ;
        endcase
    end

endmodule

//--- source/intan_chan.sv
`timescale 1ns/1ps

module intan_chan #(
    parameter int SCLK_DIV   = 2,
    parameter int FIFO_DEPTH = 4,
    parameter int SLOT       = 0
) (
    input  logic                       sys_clk,
    input  logic                       reset,
    input  logic [adc_pkg::KIND_W-1:0] kind,
    input  logic [adc_pkg::WORD_W-1:0] cmd,
    input  logic                       miso,
    output logic                       sclk,
    output logic                       cs_n,
    output logic                       mosi,
    intan_if.chan                      bus
);
    import adc_pkg::*;

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(WORD_W);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_FIN} state_t;

    state_t            state;
    op_t               op_q;
    logic [DIV_W-1:0]  div_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [WORD_W-1:0] tx_word;
    logic [WORD_W-1:0] tx_sr;
    logic [WORD_W-1:0] rx_sr;
    logic [KIND_W-1:0] kind_q;
    logic              kind_ok_q;
    logic              done_q;
    logic              half_end;
    logic              load;
    logic              rise;
    logic              shift;

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    // word sent in the frame
    always_comb begin
        case (bus.op)
            OP_CHECK: tx_word = CMD_CHECK;
            OP_CONF:  tx_word = cmd;
            default:  tx_word = CMD_CONVERT;
        endcase
    end

    assign half_end = (state == ST_SHIFT) && (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign load     = (state == ST_IDLE) && bus.start;
    assign rise     = half_end && !sclk;
    assign shift    = half_end && sclk && (bit_cnt != BIT_W'(WORD_W - 1));

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            op_q      <= OP_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b0;
            cs_n      <= 1'b1;
            mosi      <= 1'b0;
            done_q    <= 1'b0;
            kind_q    <= '0;
            kind_ok_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus.start) begin
                        state   <= ST_SHIFT;
                        op_q    <= bus.op;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        cs_n    <= 1'b0;
                        mosi    <= tx_word[WORD_W-1];
                    end
                end
                ST_SHIFT: begin
                    if (!half_end) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        if (!sclk) begin
                            sclk <= 1'b1;
                        end else if (shift) begin
                            sclk    <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                            mosi    <= tx_sr[WORD_W-2];
                        end else begin
                            // last high half done, close the frame
                            sclk  <= 1'b0;
                            cs_n  <= 1'b1;
                            mosi  <= 1'b0;
                            state <= ST_FIN;
                        end
                    end
                end
                default: begin
                    state  <= ST_IDLE;
                    done_q <= 1'b1;
                    if (op_q == OP_CHECK) begin
                        kind_q    <= kind;
                        kind_ok_q <= (rx_sr[BYTE_W-1:0] == CHIP_ID[SLOT]);
                    end
                end
            endcase
        end
    end

    // MSB first both ways, MISO taken on the rising SCLK edge
    always_ff @(posedge sys_clk) begin
        if (load) begin
            tx_sr <= tx_word;
        end else if (shift) begin
            tx_sr <= {tx_sr[WORD_W-2:0], 1'b0};
        end
        if (rise) begin
            rx_sr <= {rx_sr[WORD_W-2:0], miso};
        end
    end

    // sample FIFO, a word for a full FIFO is lost
    assign push = (state == ST_FIN) && (op_q == OP_READ) && (count != CNT_W'(FIFO_DEPTH));
    assign pop  = bus.rd_en && (count != '0);

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_sr;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign bus.done    = done_q;
    assign bus.kind    = kind_q;
    assign bus.kind_ok = kind_ok_q;
    assign bus.rd_data = mem[rd_ptr];
    assign bus.empty   = (count == '0);
    assign bus.full    = (count == CNT_W'(FIFO_DEPTH));

endmodule

//--- source/intan_ctrl.sv
`timescale 1ns/1ps

module intan_ctrl (
    input  logic                                       sys_clk,
    input  logic                                       reset,
    input  logic                                       fs_check,
    input  logic                                       fs_conf,
    input  logic                                       fs_read,
    input  logic [adc_pkg::N_SLOT*adc_pkg::KIND_W-1:0] dev_kind,
    output logic                                       fd_check,
    output logic                                       fd_conf,
    output logic                                       fd_read,
    intan_if.ctrl                                      slot [adc_pkg::N_SLOT]
);
    import adc_pkg::*;

    logic [N_SLOT-1:0] populated;
    logic [N_SLOT-1:0] pending;
    logic [N_SLOT-1:0] remain;
    logic [N_SLOT-1:0] start_q;
    logic [N_SLOT-1:0] done_vec;
    op_t               op_q;
    op_t               op_new;
    op_t               fire_op;
    logic              busy;
    logic              fs_any;
    logic              fire;

    for (genvar i = 0; i < N_SLOT; i++) begin : g_slot
        // a kind of zero marks an empty slot
        assign populated[i]  = |dev_kind[KIND_W*i +: KIND_W];
        assign done_vec[i]   = slot[i].done;
        assign slot[i].start = start_q[i];
        assign slot[i].op    = op_q;
    end

    assign fs_any = fs_check | fs_conf | fs_read;
    assign remain = pending & ~done_vec;

    // check wins over conf, conf over read
    always_comb begin
        if (fs_check) begin
            op_new = OP_CHECK;
        end else if (fs_conf) begin
            op_new = OP_CONF;
        end else begin
            op_new = OP_READ;
        end
    end

    always_comb begin
        fire    = 1'b0;
        fire_op = op_q;
        if (!busy && fs_any && populated == '0) begin
            // nothing to run, answer right away
            fire    = 1'b1;
            fire_op = op_new;
        end else if (busy && remain == '0) begin
            fire = 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            busy     <= 1'b0;
            pending  <= '0;
            start_q  <= '0;
            op_q     <= OP_IDLE;
            fd_check <= 1'b0;
            fd_conf  <= 1'b0;
            fd_read  <= 1'b0;
        end else begin
            start_q  <= '0;
            fd_check <= fire && (fire_op == OP_CHECK);
            fd_conf  <= fire && (fire_op == OP_CONF);
            fd_read  <= fire && (fire_op == OP_READ);
            if (!busy && fs_any) begin
                op_q <= op_new;
                if (populated != '0) begin
                    busy    <= 1'b1;
                    pending <= populated;
                    start_q <= populated;
                end
            end else if (busy) begin
                pending <= remain;
                if (remain == '0) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

//--- source/intan_if.sv
`timescale 1ns/1ps

interface intan_if;
    import adc_pkg::*;

    // controller to slot
    logic              start;
    op_t               op;

    // slot status
    logic              done;
    logic              kind_ok;
    logic [KIND_W-1:0] kind;

    // sample FIFO, head always visible on rd_data
    logic [WORD_W-1:0] rd_data;
    logic              empty;
    logic              full;
    logic              rd_en;

    modport ctrl (output start, output op, input done);

    modport chan (
        input  start, op, rd_en,
        output done, kind_ok, kind, rd_data, empty, full
    );

    modport drain (
        input  kind_ok, kind, rd_data, empty, full,
        output rd_en
    );

endinterface

//--- test/adc_props.sv
`timescale 1ns/1ps

module adc_props (
    input logic                       sys_clk,
    input logic                       reset,
    input logic                       fd_check,
    input logic                       fd_conf,
    input logic                       fd_read,
    input logic                       fd_fifo,
    input logic                       adc_rxen,
    input logic [adc_pkg::N_SLOT-1:0] cs_n
);

    // done strobes are one cycle wide
    a_fd_check: assert property (@(posedge sys_clk) disable iff (reset) fd_check |=> !fd_check)
        else $error("fd_check held for more than one cycle");
    a_fd_conf: assert property (@(posedge sys_clk) disable iff (reset) fd_conf |=> !fd_conf)
        else $error("fd_conf held for more than one cycle");
    a_fd_read: assert property (@(posedge sys_clk) disable iff (reset) fd_read |=> !fd_read)
        else $error("fd_read held for more than one cycle");
    a_fd_fifo: assert property (@(posedge sys_clk) disable iff (reset) fd_fifo |=> !fd_fifo)
        else $error("fd_fifo held for more than one cycle");

    // three bytes per sample, then a gap
    a_rxen_run: assert property (@(posedge sys_clk) disable iff (reset)
        adc_rxen [*3] |=> !adc_rxen)
        else $error("adc_rxen high for more than three cycles");

    // all chip selects idle once reset is released
    a_cs_idle: assert property (@(posedge sys_clk) $fell(reset) |-> (cs_n == '1))
        else $error("cs_n not high after reset");

endmodule

bind adc adc_props u_props (.*);

//--- test/adc_tb.sv
`timescale 1ns/1ps

module adc_tb;
    import adc_pkg::*;

    localparam int SCLK_DIV   = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int FRAME      = 32 * SCLK_DIV + 2;
    localparam int OP_WAIT    = FRAME + 4 * N_SLOT * FIFO_DEPTH + 20;
    localparam int MAX_LINES  = 32;

    logic                       sys_clk = 1'b0;
    logic                       reset;
    logic                       fs_check, fs_conf, fs_read, fs_fifo;
    logic                       fd_check, fd_conf, fd_read, fd_fifo;
    logic [N_SLOT*KIND_W-1:0]   dev_kind, dev_type;
    logic [N_SLOT*WORD_W-1:0]   adc_cmd;
    logic                       adc_rxen, fifoa_full, fifoa_empty;
    logic [BYTE_W-1:0]          adc_rxd;
    logic [N_SLOT-1:0]          sclk, cs_n, mosi;
    logic [N_SLOT-1:0]          miso = '0;

    // chip model state
    logic [WORD_W-1:0]          resp [N_SLOT];
    logic [WORD_W-1:0]          mosi_cap [N_SLOT];
    int                         bit_idx [N_SLOT];
    int                         frames [N_SLOT];
    logic [N_SLOT-1:0]          sclk_prev = '0;
    logic [N_SLOT-1:0]          cs_prev = '1;

    // reference FIFOs and drain pointer
    logic [WORD_W-1:0]          model_mem [N_SLOT][FIFO_DEPTH];
    int                         model_cnt [N_SLOT];
    int                         last_slot;
    logic [N_SLOT*KIND_W-1:0]   cur_type;
    logic [BYTE_W-1:0]          exp_bytes [3*N_SLOT*FIFO_DEPTH];
    int                         n_exp;

    logic [83:0]                trace_mem [MAX_LINES];
    int                         n_lines;
    int                         cycles = 0;
    int                         limit = 0;
    int                         err_cnt = 0;
    int                         miss_cnt = 0;
    int                         chk_cnt = 0;

    adc #(.SCLK_DIV(SCLK_DIV), .FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

    always #20 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("run stopped, cycle limit of %0d reached", limit);
            $display("sim failed");
            $finish;
        end
    end

    // MISO shifts on falling SCLK and MOSI is captured once SCLK is high
    always @(negedge sys_clk) begin
        for (int i = 0; i < N_SLOT; i++) begin
            if (cs_n[i]) begin
                bit_idx[i] <= WORD_W - 1;
                miso[i]    <= resp[i][WORD_W-1];
            end else if (sclk_prev[i] && !sclk[i]) begin
                bit_idx[i] <= bit_idx[i] - 1;
                miso[i]    <= resp[i][bit_idx[i]-1];
            end
            if (!cs_n[i] && !sclk_prev[i] && sclk[i]) begin
                mosi_cap[i] <= {mosi_cap[i][WORD_W-2:0], mosi[i]};
            end
            if (cs_prev[i] && !cs_n[i]) begin
                frames[i] <= frames[i] + 1;
            end
        end
        sclk_prev <= sclk;
        cs_prev   <= cs_n;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // predicts the round robin byte stream and empties the reference FIFOs
    task automatic predict_stream();
        int   j;
        logic found;
        n_exp = 0;
        for (int n = 0; n < N_SLOT * FIFO_DEPTH; n++) begin
            found = 1'b0;
            j     = 0;
            for (int k = 1; k <= N_SLOT; k++) begin
                if (!found && model_cnt[(last_slot + k) % N_SLOT] > 0) begin
                    found = 1'b1;
                    j     = (last_slot + k) % N_SLOT;
                end
            end
            if (found) begin
                last_slot            = j;
                exp_bytes[n_exp]     = {4'b0, cur_type[KIND_W*j +: KIND_W], j[1:0]};
                exp_bytes[n_exp + 1] = model_mem[j][0][15:8];
                exp_bytes[n_exp + 2] = model_mem[j][0][7:0];
                n_exp                = n_exp + 3;
                for (int d = 0; d < FIFO_DEPTH - 1; d++) begin
                    model_mem[j][d] = model_mem[j][d+1];
                end
                model_cnt[j] = model_cnt[j] - 1;
            end
        end
    endtask

    task automatic run_line(input logic [83:0] line, input int num);
        logic [3:0]        op;
        logic [N_SLOT-1:0] pop_mask;
        logic              seen;
        logic              fd_now;
        logic              exp_full;
        int                pulses;
        int                n_got;
        int                start_frames [N_SLOT];
        int                wait_cnt;
        op       = line[83:80];
        seen     = 1'b0;
        pulses   = 0;
        n_got    = 0;
        wait_cnt = 0;
        exp_full = 1'b0;
        @(negedge sys_clk);
        dev_kind = line[79:72];
        for (int i = 0; i < N_SLOT; i++) begin
            resp[i]         = line[71-16*i -: 16];
            pop_mask[i]     = |dev_kind[KIND_W*i +: KIND_W];
            start_frames[i] = frames[i];
            if (model_cnt[i] == FIFO_DEPTH) exp_full = 1'b1;
        end
        if (op == 4) begin
            chk_cnt++;
            if (fifoa_full !== exp_full) begin
                $display("Error at %0t: line %0d fifoa_full %b expected %b",
                         $time, num, fifoa_full, exp_full);
                err_cnt++;
            end
            predict_stream();
        end else begin
            n_exp = 0;
        end
        fs_check = (op == 1);
        fs_conf  = (op == 2);
        fs_read  = (op == 3);
        fs_fifo  = (op == 4);
        while ((!seen && wait_cnt < OP_WAIT) || (seen && wait_cnt < 4)) begin
            @(negedge sys_clk);
            fs_check = 1'b0;
            fs_conf  = 1'b0;
            fs_read  = 1'b0;
            fs_fifo  = 1'b0;
            wait_cnt++;
            case (op)
                1:       fd_now = fd_check;
                2:       fd_now = fd_conf;
                3:       fd_now = fd_read;
                default: fd_now = fd_fifo;
            endcase
            if (fd_now) begin
                pulses++;
                if (!seen) wait_cnt = 0;
                seen = 1'b1;
            end
            if (adc_rxen) begin
                chk_cnt++;
                if (n_got >= n_exp) begin
                    $display("Error at %0t: line %0d extra byte %h", $time, num, adc_rxd);
                    err_cnt++;
                end else if (adc_rxd !== exp_bytes[n_got]) begin
                    $display("Error at %0t: line %0d byte %0d is %h expected %h",
                             $time, num, n_got, adc_rxd, exp_bytes[n_got]);
                    err_cnt++;
                end
                n_got++;
            end
        end
        if (!seen) begin
            $display("no done strobe arrived for trace line %0d", num);
            miss_cnt++;
        end else if (pulses != 1) begin
            $display("Error at %0t: line %0d done strobe seen %0d times", $time, num, pulses);
            err_cnt++;
        end
        if (n_got != n_exp) begin
            $display("Error at %0t: line %0d got %0d bytes expected %0d",
                     $time, num, n_got, n_exp);
            err_cnt++;
        end
        for (int i = 0; i < N_SLOT; i++) begin
            chk_cnt++;
            if (frames[i] - start_frames[i] != ((op != 4 && pop_mask[i]) ? 1 : 0)) begin
                $display("Error at %0t: line %0d slot %0d ran %0d frames",
                         $time, num, i, frames[i] - start_frames[i]);
                err_cnt++;
            end
            if (op == 2 && pop_mask[i] && mosi_cap[i] !== adc_cmd[WORD_W*i +: WORD_W]) begin
                $display("Error at %0t: line %0d slot %0d mosi %h expected %h", $time, num,
                         i, mosi_cap[i], adc_cmd[WORD_W*i +: WORD_W]);
                err_cnt++;
            end
            if (op == 3 && pop_mask[i] && model_cnt[i] < FIFO_DEPTH) begin
                model_mem[i][model_cnt[i]] = resp[i];
                model_cnt[i]               = model_cnt[i] + 1;
            end
        end
        cur_type = line[7:0];
        chk_cnt++;
        if (dev_type !== cur_type) begin
            $display("Error at %0t: line %0d dev_type %h expected %h",
                     $time, num, dev_type, cur_type);
            err_cnt++;
        end
        if (op == 4 && fifoa_empty !== 1'b1) begin
            $display("Error at %0t: line %0d fifoa_empty low after drain", $time, num);
            err_cnt++;
        end
    endtask

    initial begin
        logic [15:0] st;
        reset     = 1'b1;
        fs_check  = 1'b0;
        fs_conf   = 1'b0;
        fs_read   = 1'b0;
        fs_fifo   = 1'b0;
        dev_kind  = '0;
        last_slot = N_SLOT - 1;
        cur_type  = '0;
        st        = 16'd87;
        for (int b = 0; b < N_SLOT * WORD_W; b++) begin
            st         = lfsr_step(st);
            adc_cmd[b] = st[0];
        end
        for (int i = 0; i < N_SLOT; i++) begin
            resp[i]      = '0;
            model_cnt[i] = 0;
        end
        for (int k = 0; k < MAX_LINES; k++) begin
            trace_mem[k] = '0;
        end
        $readmemh("test/adc_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && trace_mem[n_lines][83:80] != 0) begin
            n_lines++;
        end
        limit = 20 + n_lines * (OP_WAIT + 8);
        repeat (10) @(negedge sys_clk);
        reset = 1'b0;
        @(negedge sys_clk);
        if (cs_n !== '1 || dev_type !== '0 || fifoa_empty !== 1'b1 || adc_rxen !== 1'b0) begin
            $display("Error at %0t: outputs not idle after reset", $time);
            err_cnt++;
        end
        for (int k = 0; k < n_lines; k++) begin
            run_line(trace_mem[k], k);
        end
        $display("lines %0d checks %0d errors %0d missing %0d",
                 n_lines, chk_cnt, err_cnt, miss_cnt);
        if (err_cnt == 0 && miss_cnt == 0 && n_lines > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- test/adc_trace.txt
// op dev_kind resp0 resp1 resp2 resp3 dev_type
// op 1 check, 2 conf, 3 read, 4 drain
1_ff_00f0_00f4_00f8_00fc_ff
1_ff_00f0_00f4_00a8_00fc_cf
1_ff_12f0_34f4_56f8_78fc_ff
2_ff_0000_0000_0000_0000_ff
2_39_0000_0000_0000_0000_ff
3_ff_1234_5678_9abc_def0_ff
4_00_0000_0000_0000_0000_ff
3_00_0000_0000_0000_0000_ff
1_00_0000_0000_0000_0000_ff
3_3c_a5a5_0f0f_f00f_5a5a_ff
4_00_0000_0000_0000_0000_ff
1_e4_00f0_00f4_00f8_00fc_e7
3_ff_0101_0102_0103_0104_e7
3_ff_0201_0202_0203_0204_e7
3_ff_0301_0302_0303_0304_e7
3_ff_0401_0402_0403_0404_e7
3_ff_0501_0502_0503_0504_e7
4_00_0000_0000_0000_0000_e7
1_ff_00f0_00f4_00f8_00fc_ff
4_00_0000_0000_0000_0000_ff
